// File: Makefile
TOP = tb_nes_bus_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f nes_bus.f --top-module nes_bus_core
	verilator --lint-only --timing --assert -f nes_bus.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f nes_bus.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/clock_divider.sv
// Master clock divider for the CPU package.
// Produces the CPU and picture-unit clock enables from the master clock
// and tracks the get/put parity of CPU cycles. In PAL mode every fifth
// CPU cycle is stretched by one picture-unit tick, so five CPU cycles
// span 16 picture-unit ticks. A change of pal realigns both counters.

`timescale 1ns/1ps
`default_nettype none

module clock_divider #(
	parameter int div_cpu_n = nes_bus_pkg::DIV_CPU_N, // Master clocks per CPU cycle
	parameter int div_ppu_n = nes_bus_pkg::DIV_PPU_N  // Master clocks per picture-unit tick
) (
	input  logic clk,
	input  logic reset,
	input  logic pal,       // 1 = PAL timing
	output logic cpu_ce,    // One clock per CPU cycle
	output logic ppu_ce,    // One clock per picture-unit tick
	output logic put_cycle  // 1 = put (odd), 0 = get (even)
);

	localparam int CPU_W  = $clog2(div_cpu_n + 1);
	localparam int PPU_W  = $clog2(div_ppu_n + 1);
	localparam int TICK_W = $clog2(div_cpu_n / div_ppu_n + 1); // Room for the stretched cycle

	logic [CPU_W-1:0]  div_cpu;   // Counts 1..div_cpu_n
	logic [PPU_W-1:0]  div_ppu;   // Counts 1..div_ppu_n
	logic [TICK_W-1:0] ppu_tick;  // Picture-unit tick within the CPU cycle
	logic [2:0]        pal_cycle; // PAL CPU cycle within a group of five
	logic              last_pal;
	logic              stretch;

	assign cpu_ce = (div_cpu == CPU_W'(div_cpu_n));
	assign ppu_ce = (div_ppu == PPU_W'(div_ppu_n));

	// Fifth PAL cycle holds the CPU counter through its first tick
	assign stretch = (pal_cycle == 3'd4) && (ppu_tick == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu   <= CPU_W'(1);
			div_ppu   <= PPU_W'(1);
			ppu_tick  <= '0;
			pal_cycle <= '0;
			last_pal  <= pal;
			put_cycle <= 1'b1; // Starts odd
		end else begin
			last_pal <= pal;

			// Parity keeps running across a realign
			if (cpu_ce)
				put_cycle <= ~put_cycle;

			if (last_pal != pal) begin
				// Timing mode changed, restart both counters in step
				div_cpu   <= CPU_W'(1);
				div_ppu   <= PPU_W'(1);
				ppu_tick  <= '0;
				pal_cycle <= '0;
			end else begin
				if (!stretch)
					div_cpu <= cpu_ce ? CPU_W'(1) : div_cpu + CPU_W'(1);

				div_ppu <= ppu_ce ? PPU_W'(1) : div_ppu + PPU_W'(1);

				if (cpu_ce)
					ppu_tick <= '0;                   // First tick of the new CPU cycle
				else if (ppu_ce)
					ppu_tick <= ppu_tick + TICK_W'(1);

				// Group of five, only counted in PAL
				if (cpu_ce && pal)
					pal_cycle <= (pal_cycle == 3'd4) ? 3'd0 : pal_cycle + 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/data_bus_mux.sv
// Data bus selector with the open-bus latch.
// Chooses the byte returned to the CPU and to DMA reads from the joypads,
// the picture unit or memory. Addresses nobody drives return the last
// byte seen on the bus, which the latch keeps between strobes.

`timescale 1ns/1ps
`default_nettype none

module data_bus_mux (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cpu_ce,
	input  nes_bus_pkg::addr_t     bus_addr,
	input  logic                   bus_write,
	input  nes_bus_pkg::data_t     bus_dout,     // Byte being written
	input  logic                   ppu_cs,
	input  logic                   dma_active,
	input  nes_bus_pkg::data_t     mem_din,
	input  nes_bus_pkg::data_t     ppu_din,
	input  nes_bus_pkg::joy_data_t joypad1_data,
	input  nes_bus_pkg::joy_data_t joypad2_data,
	output nes_bus_pkg::data_t     cpu_din
);

	import nes_bus_pkg::*;

	data_t open_bus;  // Last byte driven on the bus
	logic  joy1_cs;
	logic  joy2_cs;
	logic  mem_cs;

	assign joy1_cs = (bus_addr[15:5] == APU_PAGE) && (bus_addr[4:0] == REG_JOY1);
	assign joy2_cs = (bus_addr[15:5] == APU_PAGE) && (bus_addr[4:0] == REG_JOY2);

	// Below the picture unit, or anywhere above the register window
	assign mem_cs = (bus_addr < PPU_BASE) || ((bus_addr >= PPU_END) && (bus_addr[15:5] != APU_PAGE));

	// Hold through the strobe clock so the sampled value stays stable
	always_ff @(posedge clk) begin
		if (reset)
			open_bus <= '0;
		else if (!cpu_ce)
			open_bus <= bus_write ? bus_dout : cpu_din;
	end

	always_comb begin
		if (joy1_cs && !dma_active) begin
			cpu_din = {open_bus[7:5], joypad1_data}; // Upper bits float
		end else if (joy2_cs && !dma_active) begin
			cpu_din = {open_bus[7:5], joypad2_data};
		end else if (ppu_cs) begin
			cpu_din = ppu_din;
		end else if (mem_cs) begin
			cpu_din = mem_din;
		end else begin
			cpu_din = open_bus;                         // Nothing drives the bus
		end
	end

endmodule

`default_nettype wire

// File: hw/dma_controller.sv
// Sprite and sample-channel DMA for the CPU package.
// A CPU write to 0x4014 latches a page and pauses the CPU. Once the CPU
// is reading, the transfer alternates a read of page:offset on a get
// cycle with a write of that byte to 0x2004 on the next put cycle.
// A DMC request steals one get cycle for a read of dmc_addr. A running
// sprite transfer falls back to waiting and repeats the lost read.

`timescale 1ns/1ps
`default_nettype none

module dma_controller (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_ce,
	input  logic               put_cycle,
	input  nes_bus_pkg::addr_t cpu_addr,
	input  logic               cpu_rnw,
	input  nes_bus_pkg::data_t cpu_dout,
	input  logic               dmc_req,   // Held until dmc_ack
	input  nes_bus_pkg::addr_t dmc_addr,
	input  nes_bus_pkg::data_t bus_din,   // Byte on the data bus
	output nes_bus_pkg::addr_t dma_addr,
	output logic               dma_active, // DMA owns the bus this cycle
	output logic               dma_read,   // 1 = read, 0 = write
	output nes_bus_pkg::data_t dma_dout,
	output logic               dmc_ack,
	output logic               pause_cpu
);

	import nes_bus_pkg::*;

	typedef enum logic [1:0] {
		SPR_IDLE = 2'b00,
		SPR_WAIT = 2'b01, // Page latched, waiting for a CPU read
		SPR_RUN  = 2'b11  // Alternating read and write
	} spr_state_t;

	spr_state_t spr_state;
	logic       dmc_state;  // DMC read pending on the coming get cycle
	data_t      spr_page;
	logic [7:0] spr_offset;
	data_t      spr_byte;   // Byte between the read and the write
	logic       get_ce;
	logic       put_ce;
	logic       sprite_trigger;
	logic       dmc_bus;
	logic       spr_bus;

	assign get_ce = cpu_ce && !put_cycle;
	assign put_ce = cpu_ce && put_cycle;

	assign sprite_trigger = cpu_ce && !cpu_rnw &&
		(cpu_addr[15:5] == APU_PAGE) && (cpu_addr[4:0] == REG_SPRITE_DMA);

	assign dmc_bus = dmc_state && !put_cycle;              // DMC wins the get cycle
	assign spr_bus = (spr_state == SPR_RUN) && !dmc_bus;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
			dmc_state <= 1'b0;
		end else begin
			if (get_ce)
				dmc_state <= 1'b0;                       // Read done at this strobe
			if (put_ce && dmc_req && cpu_rnw && !dmc_state)
				dmc_state <= 1'b1;                       // Next cycle is a get

			if (sprite_trigger) begin
				spr_state <= SPR_WAIT;
			end else begin
				case (spr_state)
					SPR_WAIT: if (put_ce && cpu_rnw) spr_state <= SPR_RUN;
					SPR_RUN: begin
						if (get_ce && dmc_state)
							spr_state <= SPR_WAIT;             // Read was stolen, redo it
						else if (put_ce && spr_offset == 8'hff)
							spr_state <= SPR_IDLE;             // 256th write done
					end
					default: spr_state <= SPR_IDLE;
				endcase
			end
		end
	end

	// Page, offset and byte latch
	always_ff @(posedge clk) begin
		if (sprite_trigger) begin
			spr_page   <= cpu_dout;
			spr_offset <= '0;
		end else if (spr_bus && put_ce) begin
			spr_offset <= spr_offset + 8'd1;             // Advance after each write
		end
		if (spr_bus && get_ce)
			spr_byte <= bus_din;
	end

	assign dma_active = dmc_bus || spr_bus;
	assign dma_read   = !put_cycle;                    // Reads on get, writes on put
	assign dma_addr   = dmc_bus ? dmc_addr : put_cycle ? OAM_DATA_ADDR : {spr_page, spr_offset};
	assign dma_dout   = spr_byte;
	assign dmc_ack    = dmc_state && get_ce;
	assign pause_cpu  = (spr_state != SPR_IDLE) || dmc_req || dmc_state;

endmodule

`default_nettype wire

// File: hw/joypad_port.sv
// Joypad strobe and clock generation.
// A CPU write to 0x4016 latches the strobe bits, which reach joypad_out
// on the next put cycle. CPU reads of 0x4016 and 0x4017 pulse the clock
// line of port 1 or port 2 for the length of the read cycle.

`timescale 1ns/1ps
`default_nettype none

module joypad_port (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_ce,
	input  logic               put_cycle,
	input  nes_bus_pkg::addr_t cpu_addr,
	input  logic               cpu_rnw,
	input  nes_bus_pkg::data_t cpu_dout,
	input  logic               dma_active,   // CPU is off the bus
	output logic [2:0]         joypad_out,   // Strobe lines OUT0..OUT2
	output logic [1:0]         joypad_clock  // Bit k clocks port k+1
);

	import nes_bus_pkg::*;

	logic       joy1_cs;
	logic       joy2_cs;
	logic       strobe_write;
	logic [2:0] strobe_latch; // Waits here for a put cycle

	assign joy1_cs = !dma_active && (cpu_addr[15:5] == APU_PAGE) && (cpu_addr[4:0] == REG_JOY1);
	assign joy2_cs = !dma_active && (cpu_addr[15:5] == APU_PAGE) && (cpu_addr[4:0] == REG_JOY2);

	assign strobe_write = cpu_ce && joy1_cs && !cpu_rnw;

	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_latch <= '0;
			joypad_out   <= '0;
		end else begin
			if (strobe_write)
				strobe_latch <= cpu_dout[2:0];
			if (cpu_ce && put_cycle)
				joypad_out <= strobe_write ? cpu_dout[2:0] : strobe_latch; // Write on a put goes straight out
		end
	end

	assign joypad_clock = {joy2_cs && cpu_rnw, joy1_cs && cpu_rnw};

endmodule

`default_nettype wire

// File: hw/nes_bus_core.sv
// Top level of the CPU package bus glue.
// Connects the clock divider, the DMA controller, the joypad port and the
// data bus selector. While DMA owns the bus its address, byte and
// direction go out; otherwise the CPU's do. The divider ratios are
// parameters so other master clock ratios can be tried.

`timescale 1ns/1ps
`default_nettype none

module nes_bus_core #(
	parameter int div_cpu_n = nes_bus_pkg::DIV_CPU_N,
	parameter int div_ppu_n = nes_bus_pkg::DIV_PPU_N
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   pal,
	input  nes_bus_pkg::addr_t     cpu_addr,
	input  logic                   cpu_rnw,
	input  nes_bus_pkg::data_t     cpu_dout,
	input  logic                   dmc_req,
	input  nes_bus_pkg::addr_t     dmc_addr,
	input  nes_bus_pkg::data_t     mem_din,
	input  nes_bus_pkg::data_t     ppu_din,
	input  nes_bus_pkg::joy_data_t joypad1_data,
	input  nes_bus_pkg::joy_data_t joypad2_data,
	output logic                   cpu_ce,
	output logic                   ppu_ce,
	output logic                   put_cycle,
	output nes_bus_pkg::addr_t     bus_addr,
	output logic                   bus_read,
	output logic                   bus_write,
	output nes_bus_pkg::data_t     bus_dout,
	output nes_bus_pkg::data_t     cpu_din,
	output logic                   pause_cpu,
	output logic                   dmc_ack,
	output logic [2:0]             joypad_out,
	output logic [1:0]             joypad_clock
);

	import nes_bus_pkg::*;

	addr_t dma_addr;
	data_t dma_dout;
	logic  dma_active;
	logic  dma_read;
	logic  ppu_cs;

	clock_divider #(
		.div_cpu_n (div_cpu_n),
		.div_ppu_n (div_ppu_n)
	) clock_divider_inst (
		.clk       (clk),
		.reset     (reset),
		.pal       (pal),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.put_cycle (put_cycle)
	);

	dma_controller dma_controller_inst (
		.clk        (clk),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.put_cycle  (put_cycle),
		.cpu_addr   (cpu_addr),
		.cpu_rnw    (cpu_rnw),
		.cpu_dout   (cpu_dout),
		.dmc_req    (dmc_req),
		.dmc_addr   (dmc_addr),
		.bus_din    (cpu_din),     // DMA reads see the same byte as the CPU
		.dma_addr   (dma_addr),
		.dma_active (dma_active),
		.dma_read   (dma_read),
		.dma_dout   (dma_dout),
		.dmc_ack    (dmc_ack),
		.pause_cpu  (pause_cpu)
	);

	joypad_port joypad_port_inst (
		.clk          (clk),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.put_cycle    (put_cycle),
		.cpu_addr     (cpu_addr),
		.cpu_rnw      (cpu_rnw),
		.cpu_dout     (cpu_dout),
		.dma_active   (dma_active),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

	// Outgoing bus, DMA takes priority over the CPU
	assign bus_addr  = dma_active ? dma_addr : cpu_addr;
	assign bus_dout  = dma_active ? dma_dout : cpu_dout;
	assign bus_read  = dma_active ? dma_read : cpu_rnw;
	assign bus_write = dma_active ? !dma_read : !cpu_rnw;

	assign ppu_cs = (bus_addr >= PPU_BASE) && (bus_addr < PPU_END); // 0x2000..0x3FFF

	data_bus_mux data_bus_mux_inst (
		.clk          (clk),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.bus_addr     (bus_addr),
		.bus_write    (bus_write),
		.bus_dout     (bus_dout),
		.ppu_cs       (ppu_cs),
		.dma_active   (dma_active),
		.mem_din      (mem_din),
		.ppu_din      (ppu_din),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.cpu_din      (cpu_din)
	);

endmodule

`default_nettype wire

// File: hw/nes_bus_pkg.sv
// Shared definitions for the console bus glue.
// Holds the bus widths, the register addresses inside the CPU map and
// the master clock divider ratios. Modules import it inside their body
// and use scoped names in their port lists.

`default_nettype none

package nes_bus_pkg;

	// Bus widths
	typedef logic [15:0] addr_t;     // CPU address bus
	typedef logic [7:0]  data_t;     // One bus byte
	typedef logic [4:0]  joy_data_t; // Joypad data lines D0..D4

	// Master clocks per enable strobe
	localparam int DIV_CPU_N = 12; // One CPU cycle
	localparam int DIV_PPU_N = 4;  // One picture-unit tick

	// Sprite DMA always writes to the object-attribute data port
	localparam addr_t OAM_DATA_ADDR = 16'h2004;

	// Register window 0x4000..0x401F, selected by the upper 11 address bits
	localparam logic [10:0] APU_PAGE = 11'b0100_0000_000;

	// Registers within the window, low 5 address bits
	localparam logic [4:0] REG_SPRITE_DMA = 5'h14; // Write starts sprite DMA
	localparam logic [4:0] REG_JOY1       = 5'h16; // Strobe write, port 1 read
	localparam logic [4:0] REG_JOY2       = 5'h17; // Port 2 read

	// Picture-unit registers, mirrored every 8 bytes
	localparam addr_t PPU_BASE = 16'h2000; // First address of the range
	localparam addr_t PPU_END  = 16'h4000; // First address past the range

endpackage

`default_nettype wire

// File: nes_bus.f
hw/nes_bus_pkg.sv
hw/clock_divider.sv
hw/dma_controller.sv
hw/joypad_port.sv
hw/data_bus_mux.sv
hw/nes_bus_core.sv
test/nes_bus_assert.sv
test/tb_nes_bus_core.sv

// File: test/nes_bus_assert.sv
// Concurrent checks on the DMA controller and the clock enables.
// Bound into dma_controller by the testbench, which adds fail_count
// to its error total at the end of the run.

`timescale 1ns/1ps
`default_nettype none

module nes_bus_assert (
	input logic clk,
	input logic reset,
	input logic cpu_ce,
	input logic dma_active,
	input logic dma_read,
	input logic dmc_req,
	input logic dmc_ack,
	input logic pause_cpu
);

	int   fail_count = 0; // Failed assertions so far
	logic put_ref;        // Own get/put parity, odd after reset

	always_ff @(posedge clk) begin
		if (reset)
			put_ref <= 1'b1;
		else if (cpu_ce)
			put_ref <= ~put_ref;
	end

	// Ack only while the request is still held
	dmc_ack_with_req: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> dmc_req)
	else begin
		$error("dmc_ack high without dmc_req");
		fail_count++;
	end

	dma_pauses_cpu: assert property (@(posedge clk) disable iff (reset)
		dma_active |-> pause_cpu)
	else begin
		$error("DMA owns the bus but CPU not paused");
		fail_count++;
	end

	// Writes belong to put cycles by the parity counted here
	write_on_put: assert property (@(posedge clk) disable iff (reset)
		(dma_active && !dma_read) |-> put_ref)
	else begin
		$error("DMA write on a get cycle");
		fail_count++;
	end

	ce_single: assert property (@(posedge clk) disable iff (reset)
		cpu_ce |=> !cpu_ce)
	else begin
		$error("cpu_ce wider than one clock");
		fail_count++;
	end

endmodule

`default_nettype wire

// File: test/tb_nes_bus_core.sv
// Testbench for the bus glue top level.
// Acts as CPU, memory, picture unit and sample channel. Checks divider
// timing, sprite DMA with and without a DMC steal, joypads and the data
// bus selection. A monitor compares every OAM write at cpu_ce.

`timescale 1ns/1ps
`default_nettype none

module tb_nes_bus_core;

	import nes_bus_pkg::*;

	localparam logic [31:0] LFSR_SEED = 32'h92c66df9;
	localparam data_t DATA_SEED = 8'h5a;      // Memory fill pattern seed
	localparam int TIMEOUT_MARGIN = 2000;
	localparam int TIMEOUT_CYCLES = (2 * 530 + 40) * DIV_CPU_N + 700 + TIMEOUT_MARGIN;

	logic clk, reset, pal, cpu_rnw, dmc_req;
	addr_t cpu_addr, dmc_addr, bus_addr;
	data_t cpu_dout, mem_din, ppu_din, bus_dout, cpu_din;
	joy_data_t joypad1_data, joypad2_data;
	logic cpu_ce, ppu_ce, put_cycle, bus_read, bus_write, pause_cpu, dmc_ack;
	logic [2:0] joypad_out;
	logic [1:0] joypad_clock;

	logic [31:0] lfsr_state;
	int err_main, err_mon, err_assert, cycle_count;
	int oam_writes, dmc_acks;  // Counted by the monitor
	logic [7:0] spr_idx;       // Next expected sprite offset
	data_t exp_page;
	data_t rd_data;            // Byte seen by the CPU at cpu_ce
	logic [1:0] smp_clock;

	nes_bus_core #(.div_cpu_n(DIV_CPU_N), .div_ppu_n(DIV_PPU_N)) nes_bus_core_inst (.*);

	bind dma_controller nes_bus_assert nes_bus_assert_inst (
		.clk(clk), .reset(reset), .cpu_ce(cpu_ce),
		.dma_active(dma_active), .dma_read(dma_read), .dmc_req(dmc_req),
		.dmc_ack(dmc_ack), .pause_cpu(pause_cpu)
	);

	// Memory contents fold in every address bit
	function automatic data_t mem_byte(input addr_t a);
		return a[7:0] ^ {a[12:8], a[15:13]} ^ DATA_SEED;
	endfunction

	// Joypad read keeps the upper three bits of the last bus byte
	function automatic data_t joy_expect(input data_t last, input joy_data_t joy);
		return {last[7:5], joy};
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // One step per bit
			v = {v[14:0], lfsr_state[0]};
		end
	endtask

	task automatic wait_ce();
		do @(posedge clk); while (!cpu_ce);
	endtask

	// One CPU bus cycle driven right after a strobe
	task automatic cpu_access(input addr_t addr, input logic rnw, input data_t dout);
		cpu_addr <= addr;
		cpu_rnw  <= rnw;
		cpu_dout <= dout;
		wait_ce();
		rd_data   = cpu_din;
		smp_clock = joypad_clock;
	endtask

	task automatic fail_value(input string what, input int got, input int exp);
		$display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, exp);
		err_main++;
	endtask

	// Sprite DMA of page p with an optional DMC steal in the middle
	task automatic sprite_dma(input data_t p, input logic with_dmc);
		int start_w;
		int start_a;
		logic sent;
		logic [15:0] r;
		start_w = oam_writes;
		start_a = dmc_acks;
		sent = 1'b0;
		exp_page = p;
		cpu_access({APU_PAGE, REG_SPRITE_DMA}, 1'b0, p);
		cpu_addr <= 16'h0100;             // CPU keeps reading while paused
		cpu_rnw  <= 1'b1;
		@(posedge clk);
		if (!pause_cpu)
			fail_value("pause_cpu after trigger", 0, 1);
		while (pause_cpu) begin
			if (with_dmc && !sent && (oam_writes - start_w) >= 40) begin
				rand_bits(14, r);
				dmc_addr <= {2'b11, r[13:0]};
				dmc_req  <= 1'b1;
				sent = 1'b1;
			end else if (dmc_req && dmc_ack) begin
				dmc_req <= 1'b0;                  // Ack seen for one cycle
			end
			@(posedge clk);
		end
		if (oam_writes - start_w != 256)
			fail_value("OAM write count", oam_writes - start_w, 256);
		if (dmc_acks - start_a != (with_dmc ? 1 : 0))
			fail_value("DMC ack count", dmc_acks - start_a, with_dmc ? 1 : 0);
		wait_ce();
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Bus monitor comparing at every strobe
	always @(posedge clk) begin
		if (!reset && cpu_ce) begin
			if (bus_write && bus_addr == OAM_DATA_ADDR) begin
				if (bus_dout !== mem_byte({exp_page, spr_idx})) begin
					$display("[ERROR] %0t: OAM byte %0d got %0h expected %0h", $time, spr_idx,
						bus_dout, mem_byte({exp_page, spr_idx}));
					err_mon++;
				end
				spr_idx    <= spr_idx + 8'd1;
				oam_writes <= oam_writes + 1;
			end
			if (bus_write && bus_addr == {APU_PAGE, REG_SPRITE_DMA})
				spr_idx <= 8'd0;                    // New transfer starts at offset 0
			if (dmc_ack) begin
				dmc_acks <= dmc_acks + 1;
				if (bus_addr !== dmc_addr || !bus_read || cpu_din !== mem_byte(dmc_addr)) begin
					$display("[ERROR] %0t: DMC read of %0h wrong", $time, dmc_addr);
					err_mon++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	assign mem_din = mem_byte(bus_addr); // Memory answers combinationally

	initial begin
		logic [15:0] r;
		int cnt;
		data_t b;
		logic par;
		lfsr_state = LFSR_SEED;
		err_main = 0;
		err_mon = 0;
		cycle_count = 0;
		oam_writes = 0;
		dmc_acks = 0;
		spr_idx = '0;
		exp_page = '0;
		reset = 1'b1;
		pal = 1'b0;
		cpu_addr = '0;
		cpu_rnw = 1'b1;
		cpu_dout = '0;
		dmc_req = 1'b0;
		dmc_addr = 16'hc000;
		ppu_din = '0;
		joypad1_data = '0;
		joypad2_data = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		if (pause_cpu || dmc_ack || bus_write || joypad_clock != 2'b00 || put_cycle !== 1'b1)
			fail_value("outputs after reset", 1, 0);

		// NTSC strobe spacing and put_cycle flipping at every strobe
		wait_ce();
		par = put_cycle;
		for (int k = 0; k < 5; k++) begin
			cnt = 0;
			do begin
				@(posedge clk);
				cnt++;
			end while (!cpu_ce);
			if (cnt != DIV_CPU_N)
				fail_value("cpu_ce spacing", cnt, DIV_CPU_N);
			if (put_cycle === par)
				fail_value("put_cycle toggle", put_cycle, !par);
			par = put_cycle;
		end
		do @(posedge clk); while (!ppu_ce);
		for (int k = 0; k < 5; k++) begin
			cnt = 0;
			do begin
				@(posedge clk);
				cnt++;
			end while (!ppu_ce);
			if (cnt != DIV_PPU_N)
				fail_value("ppu_ce spacing", cnt, DIV_PPU_N);
		end
		wait_ce();

		// Picture unit, memory and open bus
		rand_bits(8, r);
		ppu_din <= r[7:0];
		cpu_access(16'h2002, 1'b1, '0);
		if (rd_data !== r[7:0])
			fail_value("PPU read", rd_data, r[7:0]);
		rand_bits(13, r);
		cpu_access({3'b100, r[12:0]}, 1'b1, '0);
		if (rd_data !== mem_byte({3'b100, r[12:0]}))
			fail_value("memory read", rd_data, mem_byte({3'b100, r[12:0]}));
		rand_bits(8, r);
		cpu_access(16'h4018, 1'b0, r[7:0]);
		cpu_access(16'h4018, 1'b1, '0);
		if (rd_data !== r[7:0])
			fail_value("open bus read", rd_data, r[7:0]);

		// Joypad strobe and port 2 read
		rand_bits(8, r);
		b = r[7:0];
		if (b[2:0] == 3'b000)
			b[2:0] = 3'b101;                    // Differs from the reset value of joypad_out
		rand_bits(5, r);
		joypad2_data <= r[4:0];
		cpu_access({APU_PAGE, REG_JOY1}, 1'b0, b);
		cpu_access({APU_PAGE, REG_JOY2}, 1'b1, '0);
		if (rd_data !== joy_expect(b, r[4:0]))
			fail_value("joypad 2 read", rd_data, joy_expect(b, r[4:0]));
		if (smp_clock !== 2'b10)
			fail_value("joypad_clock", smp_clock, 2);
		cpu_access(16'h0010, 1'b1, '0);
		if (joypad_out !== b[2:0])
			fail_value("joypad_out", joypad_out, b[2:0]);

		// Two sprite transfers with a DMC steal in the second
		for (int k = 0; k < 2; k++) begin
			rand_bits(8, r);
			b = r[7:0];
			if (b >= 8'h20 && b <= 8'h40)
				b = b ^ 8'h80;                    // Keep the page in memory space
			sprite_dma(b, k == 1);
		end

		// PAL packs five CPU cycles into 64 clocks
		pal <= 1'b1;
		repeat (4) @(posedge clk);
		cnt = 0;
		repeat (640) begin
			@(posedge clk);
			if (cpu_ce)
				cnt++;
		end
		if (cnt < 49 || cnt > 51)
			fail_value("PAL cpu_ce count", cnt, 50);

		err_assert = nes_bus_core_inst.dma_controller_inst.nes_bus_assert_inst.fail_count;
		$display("Errors: %0d in sequence checks, %0d in bus monitor, %0d in assertions",
			err_main, err_mon, err_assert);
		if (err_main + err_mon + err_assert == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
